//--- ice_bus_pkg.sv
package ice_bus_pkg;

	// Command type bytes from the host
	localparam logic [7:0] CMD_VERSION = "V";
	localparam logic [7:0] CMD_SET = "_";
	localparam logic [7:0] CMD_GET = "?";

	// Response type bytes
	localparam logic [7:0] TYPE_ACK = 8'h00;
	localparam logic [7:0] TYPE_NAK = 8'h01;

	// Unsolicited GPIO change report
	localparam logic [7:0] TYPE_GPIO_EVT = "g";

	// Reported by the version query
	localparam logic [7:0] VERSION_MAJOR = 8'd0;
	localparam logic [7:0] VERSION_MINOR = 8'd4;

	// One byte on the shared response bus
	// Last marks the final byte of a response frame
	typedef struct packed {
		logic valid;
		logic last;
		logic [7:0] data;
	} sl_word_t;

endpackage

//--- ice_cfg_pkg.sv
package ice_cfg_pkg;

	// Setting ids, first payload byte of a set or get frame
	localparam logic [7:0] SET_ID_DIRECTION = "d";
	localparam logic [7:0] SET_ID_LEVEL = "l";

	// Event id carried by GPIO event frames
	// Counts frames sent, wraps at 256
	typedef logic [7:0] evt_tag_t;

endpackage

//--- ice_ma_if.sv
`timescale 1ns/1ps

interface ice_ma_if;

	// Frame type, stable while the frame is open
	logic [7:0] ma_addr;
	// Host event id, echoed in the reply
	logic [7:0] ma_event_id;
	// Payload byte, qualified by ma_data_valid
	logic [7:0] ma_data;
	// One pulse per payload byte
	logic ma_data_valid;
	// High while a frame is open
	// Peers decode on its falling edge
	logic ma_frame_valid;

	// Frame controller side
	modport master (
		output ma_addr, ma_event_id, ma_data, ma_data_valid, ma_frame_valid
	);

	// Peer side
	modport slave (
		input ma_addr, ma_event_id, ma_data, ma_data_valid, ma_frame_valid
	);

endinterface

//--- ice_frame_ctrl.sv
`timescale 1ns/1ps

module ice_frame_ctrl import ice_bus_pkg::*; (
	input  logic       reset,
	input  logic       clk,
	// Host bytes in, one strobe per byte
	input  logic [7:0] rx_char,
	input  logic       rx_char_valid,
	// Host bytes out, host takes one per cycle
	output logic [7:0] tx_char,
	output logic       tx_char_valid,
	// Command broadcast to all peers
	ice_ma_if.master   ma,
	// Word of the currently granted peer
	input  sl_word_t   resp_word
);

	// Frame layout: type, event id, length, payload
	typedef enum logic [1:0] {
		ST_TYPE,
		ST_EVENT,
		ST_LEN,
		ST_PAYLOAD
	} parse_state_t;

	parse_state_t state;
	// Payload bytes still expected
	logic [7:0] remain;
	// Closes the frame on the next edge
	logic frame_close;

	// Parser and master bus strobes
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			state <= ST_TYPE;
			remain <= '0;
			frame_close <= 1'b0;
			ma.ma_frame_valid <= 1'b0;
			ma.ma_data_valid <= 1'b0;
		end else begin
			// Data strobe is a single cycle
			ma.ma_data_valid <= 1'b0;
			// Frame level drops one cycle after the last strobe
			if (frame_close) begin
				ma.ma_frame_valid <= 1'b0;
				frame_close <= 1'b0;
			end
			if (rx_char_valid) begin
				case (state)
					ST_TYPE: begin
						state <= ST_EVENT;
					end
					ST_EVENT: begin
						state <= ST_LEN;
					end
					ST_LEN: begin
						remain <= rx_char;
						// Frame opens once the length is known
						ma.ma_frame_valid <= 1'b1;
						if (rx_char == 8'd0) begin
							// Empty frame, open for a single cycle
							frame_close <= 1'b1;
							state <= ST_TYPE;
						end else begin
							state <= ST_PAYLOAD;
						end
					end
					ST_PAYLOAD: begin
						remain <= remain - 8'd1;
						ma.ma_data_valid <= 1'b1;
						if (remain == 8'd1) begin
							frame_close <= 1'b1;
							state <= ST_TYPE;
						end
					end
					default: begin
						state <= ST_TYPE;
					end
				endcase
			end
		end
	end

	// Held frame fields and payload byte
	always_ff @(posedge reset) begin
		if (rx_char_valid) begin
			if (state == ST_TYPE) begin
				ma.ma_addr <= rx_char;
			end
			if (state == ST_EVENT) begin
				ma.ma_event_id <= rx_char;
			end
			if (state == ST_PAYLOAD) begin
				ma.ma_data <= rx_char;
			end
		end
	end

	// Response path
	// Arbiter already muxes the granted word, so one register stage here
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			tx_char_valid <= 1'b0;
		end else begin
			tx_char_valid <= resp_word.valid;
		end
	end

	// Byte holds between words
	always_ff @(posedge reset) begin
		if (resp_word.valid) begin
			tx_char <= resp_word.data;
		end
	end

endmodule

//--- ice_resp_arbiter.sv
`timescale 1ns/1ps

module ice_resp_arbiter import ice_bus_pkg::*; #(
	parameter int NUM_DEV = 2
) (
	input  logic               reset,
	input  logic               clk,
	// One request and grant bit per peer
	input  logic [NUM_DEV-1:0] sl_request,
	output logic [NUM_DEV-1:0] sl_grant,
	// Words from every peer, only the granted one passes
	input  sl_word_t           peer_word [NUM_DEV],
	output sl_word_t           resp_word
);

	// Lowest requesting index
	logic [NUM_DEV-1:0] pick;

	// Isolate lowest set bit
	assign pick = sl_request & (~sl_request + NUM_DEV'(1));

	// Grant locks for a whole response frame
	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			sl_grant <= '0;
		end else if (|sl_grant) begin
			// Released the cycle after the last word
			if (resp_word.valid && resp_word.last) begin
				sl_grant <= '0;
			end
		end else begin
			sl_grant <= pick;
		end
	end

	// Word mux, one-hot select
	always_comb begin
		resp_word = '0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (sl_grant[i]) begin
				resp_word = peer_word[i];
			end
		end
	end

endmodule

//--- ice_basics.sv
`timescale 1ns/1ps

module ice_basics import ice_bus_pkg::*, ice_cfg_pkg::*; #(
	parameter int GPIO_WIDTH = 16
) (
	input  logic                  reset,
	input  logic                  clk,
	ice_ma_if.slave               ma,
	output logic                  sl_request,
	input  logic                  sl_grant,
	output sl_word_t              sl_word,
	// Settings consumed by the GPIO peer
	output logic [GPIO_WIDTH-1:0] gpio_level,
	output logic [GPIO_WIDTH-1:0] gpio_direction
);

	localparam int NB = GPIO_WIDTH / 8;
	// Reply payload holds a setting or the two version bytes
	localparam int PAY_W = (GPIO_WIDTH > 16) ? GPIO_WIDTH : 16;
	localparam int CNT_W = $clog2(NB + 2);

	logic fv_q;
	logic frame_end;
	logic accept;
	logic [7:0] frm_type;
	logic [7:0] frm_id;
	// Setting id plus value bytes, extra bytes dropped
	logic [CNT_W-1:0] pay_cnt;
	logic [7:0] pay_buf [NB+1];
	logic [GPIO_WIDTH-1:0] wr_value;
	logic id_dir;
	logic id_lvl;
	logic wr_ok;
	logic rd_ok;
	logic sending;
	logic [7:0] word_idx;
	logic [7:0] resp_type;
	logic [7:0] resp_id;
	logic [7:0] resp_len;
	logic [PAY_W-1:0] resp_pay;

	assign frame_end = fv_q & ~ma.ma_frame_valid;
	// Frames during a pending reply are dropped
	assign accept = frame_end & ~sl_request;

	// Value arrives MSB first
	always_comb begin
		for (int k = 0; k < NB; k++) begin
			wr_value[GPIO_WIDTH-1-8*k -: 8] = pay_buf[k+1];
		end
	end

	assign id_dir = (pay_buf[0] == SET_ID_DIRECTION);
	assign id_lvl = (pay_buf[0] == SET_ID_LEVEL);
	// Write needs the id and a full value
	assign wr_ok = (pay_cnt == CNT_W'(NB + 1)) && (id_dir || id_lvl);
	assign rd_ok = (pay_cnt != '0) && (id_dir || id_lvl);

	// Capture header and payload while the frame is open
	always_ff @(posedge reset) begin
		if (ma.ma_frame_valid) begin
			frm_type <= ma.ma_addr;
			frm_id <= ma.ma_event_id;
		end
		if (ma.ma_data_valid && pay_cnt <= CNT_W'(NB)) begin
			pay_buf[pay_cnt] <= ma.ma_data;
		end
	end

	// Reply contents, decoded at frame end
	always_ff @(posedge reset) begin
		if (accept) begin
			resp_id <= frm_id;
			resp_type <= TYPE_NAK;
			resp_len <= 8'd0;
			resp_pay <= PAY_W'(id_dir ? gpio_direction : gpio_level) << (PAY_W - GPIO_WIDTH);
			case (frm_type)
				CMD_VERSION: begin
					resp_type <= CMD_VERSION;
					resp_len <= 8'd2;
					resp_pay <= PAY_W'({VERSION_MAJOR, VERSION_MINOR}) << (PAY_W - 16);
				end
				CMD_SET: begin
					if (wr_ok) begin
						resp_type <= TYPE_ACK;
					end
				end
				CMD_GET: begin
					if (rd_ok) begin
						resp_type <= TYPE_ACK;
						resp_len <= 8'(NB);
					end
				end
				default: begin
					resp_type <= TYPE_NAK;
				end
			endcase
		end else if (sending && word_idx >= 8'd3) begin
			// Next payload byte to the top
			resp_pay <= resp_pay << 8;
		end
	end

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			fv_q <= 1'b0;
			pay_cnt <= '0;
			gpio_level <= '0;
			gpio_direction <= '0;
			sl_request <= 1'b0;
			sending <= 1'b0;
			word_idx <= '0;
		end else begin
			fv_q <= ma.ma_frame_valid;
			if (frame_end) begin
				pay_cnt <= '0;
			end else if (ma.ma_data_valid && pay_cnt != CNT_W'(NB + 1)) begin
				pay_cnt <= pay_cnt + 1'b1;
			end
			if (accept) begin
				sl_request <= 1'b1;
				if (frm_type == CMD_SET && wr_ok && id_dir) begin
					gpio_direction <= wr_value;
				end
				if (frm_type == CMD_SET && wr_ok && id_lvl) begin
					gpio_level <= wr_value;
				end
			end
			// Words start the cycle after the grant is seen
			if (sl_request && sl_grant && !sending) begin
				sending <= 1'b1;
				word_idx <= '0;
			end else if (sending) begin
				word_idx <= word_idx + 8'd1;
				if (sl_word.last) begin
					sending <= 1'b0;
					sl_request <= 1'b0;
				end
			end
		end
	end

	// Header bytes, then payload
	always_comb begin
		sl_word.valid = sending;
		sl_word.last = sending && (word_idx == resp_len + 8'd2);
		case (word_idx)
			8'd0: sl_word.data = resp_type;
			8'd1: sl_word.data = resp_id;
			8'd2: sl_word.data = resp_len;
			default: sl_word.data = resp_pay[PAY_W-1 -: 8];
		endcase
	end

endmodule

//--- ice_gpio.sv
`timescale 1ns/1ps

module ice_gpio import ice_bus_pkg::*, ice_cfg_pkg::*; #(
	parameter int GPIO_WIDTH = 16
) (
	input  logic                  reset,
	input  logic                  clk,
	// Settings from the basics peer
	input  logic [GPIO_WIDTH-1:0] gpio_level,
	input  logic [GPIO_WIDTH-1:0] gpio_direction,
	// Pad side
	input  logic [GPIO_WIDTH-1:0] gpio_in,
	output logic [GPIO_WIDTH-1:0] gpio_out,
	output logic [GPIO_WIDTH-1:0] gpio_oe,
	output logic                  sl_request,
	input  logic                  sl_grant,
	output sl_word_t              sl_word
);

	localparam int NB = GPIO_WIDTH / 8;

	logic [GPIO_WIDTH-1:0] sync_1;
	logic [GPIO_WIDTH-1:0] sync_2;
	// Previous synchronized value for edge detection
	logic [GPIO_WIDTH-1:0] in_q;
	// Inputs with output bits forced low
	logic [GPIO_WIDTH-1:0] in_mask;
	logic change;
	logic pending;
	logic start;
	logic sending;
	logic [7:0] word_idx;
	evt_tag_t tag;
	logic [GPIO_WIDTH-1:0] evt_bits;

	// Direction bit 1 drives the pad
	assign gpio_oe = gpio_direction;
	assign gpio_out = gpio_level & gpio_direction;

	assign in_mask = sync_2 & ~gpio_direction;
	// Only input-direction bits raise events
	assign change = |((sync_2 ^ in_q) & ~gpio_direction);
	assign start = sl_request & sl_grant & ~sending;

	always_ff @(posedge reset or posedge clk) begin
		if (clk) begin
			sync_1 <= '0;
			sync_2 <= '0;
			in_q <= '0;
			pending <= 1'b0;
			sl_request <= 1'b0;
			sending <= 1'b0;
			word_idx <= '0;
			tag <= '0;
		end else begin
			sync_1 <= gpio_in;
			sync_2 <= sync_1;
			in_q <= sync_2;
			if (start) begin
				sending <= 1'b1;
				word_idx <= '0;
				// Sample covers earlier changes, a change right now stays pending
				pending <= change;
			end else begin
				if (change) begin
					pending <= 1'b1;
				end
				if (sending) begin
					word_idx <= word_idx + 8'd1;
					if (sl_word.last) begin
						sending <= 1'b0;
						sl_request <= 1'b0;
						tag <= tag + evt_tag_t'(1);
					end
				end else if (pending && !sl_request) begin
					sl_request <= 1'b1;
				end
			end
		end
	end

	// Input snapshot at grant, shifted out MSB first
	always_ff @(posedge reset) begin
		if (start) begin
			evt_bits <= in_mask;
		end else if (sending && word_idx >= 8'd3) begin
			evt_bits <= evt_bits << 8;
		end
	end

	always_comb begin
		sl_word.valid = sending;
		sl_word.last = sending && (word_idx == 8'(NB + 2));
		case (word_idx)
			8'd0: sl_word.data = TYPE_GPIO_EVT;
			8'd1: sl_word.data = tag;
			8'd2: sl_word.data = 8'(NB);
			default: sl_word.data = evt_bits[GPIO_WIDTH-1 -: 8];
		endcase
	end

endmodule

//--- ice_bus.sv
`timescale 1ns/1ps

module ice_bus import ice_bus_pkg::*; #(
	parameter int NUM_DEV = 2,
	parameter int GPIO_WIDTH = 16
) (
	input  logic                  reset,
	input  logic                  clk,
	// Host byte stream
	input  logic [7:0]            rx_char,
	input  logic                  rx_char_valid,
	output logic [7:0]            tx_char,
	output logic                  tx_char_valid,
	// GPIO pads
	input  logic [GPIO_WIDTH-1:0] gpio_in,
	output logic [GPIO_WIDTH-1:0] gpio_out,
	output logic [GPIO_WIDTH-1:0] gpio_oe
);

	// Command broadcast
	ice_ma_if u_ma ();

	// Response bus, basics at 0 and GPIO at 1
	logic [NUM_DEV-1:0] sl_request;
	logic [NUM_DEV-1:0] sl_grant;
	sl_word_t peer_word [NUM_DEV];
	sl_word_t resp_word;

	// Settings from basics to GPIO
	logic [GPIO_WIDTH-1:0] gpio_level;
	logic [GPIO_WIDTH-1:0] gpio_direction;

	ice_frame_ctrl u_frame_ctrl (
		.reset         (reset),
		.clk           (clk),
		.rx_char       (rx_char),
		.rx_char_valid (rx_char_valid),
		.tx_char       (tx_char),
		.tx_char_valid (tx_char_valid),
		.ma            (u_ma.master),
		.resp_word     (resp_word)
	);

	ice_resp_arbiter #(
		.NUM_DEV (NUM_DEV)
	) u_arbiter (
		.reset      (reset),
		.clk        (clk),
		.sl_request (sl_request),
		.sl_grant   (sl_grant),
		.peer_word  (peer_word),
		.resp_word  (resp_word)
	);

	ice_basics #(
		.GPIO_WIDTH (GPIO_WIDTH)
	) u_basics (
		.reset          (reset),
		.clk            (clk),
		.ma             (u_ma.slave),
		.sl_request     (sl_request[0]),
		.sl_grant       (sl_grant[0]),
		.sl_word        (peer_word[0]),
		.gpio_level     (gpio_level),
		.gpio_direction (gpio_direction)
	);

	// Event source, answers no commands
	ice_gpio #(
		.GPIO_WIDTH (GPIO_WIDTH)
	) u_gpio (
		.reset          (reset),
		.clk            (clk),
		.gpio_level     (gpio_level),
		.gpio_direction (gpio_direction),
		.gpio_in        (gpio_in),
		.gpio_out       (gpio_out),
		.gpio_oe        (gpio_oe),
		.sl_request     (sl_request[1]),
		.sl_grant       (sl_grant[1]),
		.sl_word        (peer_word[1])
	);

endmodule

//--- ice_bus_properties.sv
`timescale 1ns/1ps

module ice_bus_properties #(
	parameter int NUM_DEV = 2
) (
	input logic               reset,
	input logic               clk,
	input logic [NUM_DEV-1:0] sl_request,
	input logic [NUM_DEV-1:0] sl_grant,
	input logic               ma_data_valid,
	input logic               ma_frame_valid,
	input logic               tx_char_valid
);

	// Count of failed assertions
	int fail_cnt = 0;

	// At most one peer owns the response bus
	grant_onehot: assert property (@(posedge reset) disable iff (clk) $onehot0(sl_grant))
		else begin
			fail_cnt++;
			$error("sl_grant has more than one bit set");
		end

	// Grant only to a requesting peer
	grant_requested: assert property (@(posedge reset) disable iff (clk)
		(sl_grant & ~sl_request) == '0)
		else begin
			fail_cnt++;
			$error("sl_grant set for a peer without a request");
		end

	// Payload strobes stay inside the frame
	data_in_frame: assert property (@(posedge reset) disable iff (clk)
		ma_data_valid |-> ma_frame_valid)
		else begin
			fail_cnt++;
			$error("ma_data_valid seen outside ma_frame_valid");
		end

	// Quiet host output during reset
	tx_quiet_in_reset: assert property (@(posedge reset) clk |-> !tx_char_valid)
		else begin
			fail_cnt++;
			$error("tx_char_valid high during reset");
		end

endmodule

bind ice_bus ice_bus_properties #(
	.NUM_DEV (NUM_DEV)
) u_props (
	.reset          (reset),
	.clk            (clk),
	.sl_request     (sl_request),
	.sl_grant       (sl_grant),
	.ma_data_valid  (u_ma.ma_data_valid),
	.ma_frame_valid (u_ma.ma_frame_valid),
	.tx_char_valid  (tx_char_valid)
);

//--- tb_ice_bus.sv
`timescale 1ns/1ps

module tb_ice_bus import ice_bus_pkg::*, ice_cfg_pkg::*; ();

	localparam int GPIO_WIDTH = 16;
	localparam int NB = GPIO_WIDTH / 8;
	// Five tests of at most about 400 cycles each, with margin
	localparam int TIMEOUT_CYCLES = 4000;

	// Clock
	logic reset;
	// Active-high asynchronous reset
	logic clk;
	logic [7:0] rx_char;
	logic rx_char_valid;
	logic [7:0] tx_char;
	logic tx_char_valid;
	logic [GPIO_WIDTH-1:0] gpio_in;
	logic [GPIO_WIDTH-1:0] gpio_out;
	logic [GPIO_WIDTH-1:0] gpio_oe;

	// Host output bytes not yet taken as frames
	logic [7:0] tx_q [$];
	// Frame most recently taken off tx_q
	logic [7:0] frm [$];
	logic [31:0] rng_state = 32'h656d;
	string test_name;
	int errors = 0;
	int err_at_start = 0;
	int tests = 0;
	int cycles = 0;
	// Byte position inside the current output frame
	int tx_pos = 0;
	int tx_len = 0;
	// Next tag expected from the GPIO peer
	evt_tag_t evt_cnt = '0;
	logic [GPIO_WIDTH-1:0] dir_set;

	ice_bus #(
		.NUM_DEV    (2),
		.GPIO_WIDTH (GPIO_WIDTH)
	) u_ice_bus (
		.reset         (reset),
		.clk           (clk),
		.rx_char       (rx_char),
		.rx_char_valid (rx_char_valid),
		.tx_char       (tx_char),
		.tx_char_valid (tx_char_valid),
		.gpio_in       (gpio_in),
		.gpio_out      (gpio_out),
		.gpio_oe       (gpio_oe)
	);

	initial begin
		reset = 1'b0;
		forever #20 reset = ~reset;
	end

	// Watchdog
	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge reset);
			cycles++;
		end
		$display("Timeout after %0d cycles, an expected response never came", cycles);
		$display("Verification failed");
		$finish;
	end

	// Response collector, outputs settle before the falling edge
	always @(negedge reset) begin
		if (tx_char_valid) begin
			tx_q.push_back(tx_char);
			if (tx_pos == 2) begin
				tx_len = tx_char;
			end
			tx_pos++;
			if (tx_pos >= 3 && tx_pos == tx_len + 3) begin
				tx_pos = 0;
			end
		end else if (tx_pos != 0) begin
			$display("%s: output frame broke off after %0d bytes", test_name, tx_pos);
			errors++;
			tx_pos = 0;
		end
	end

	function automatic logic [31:0] xorshift();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Payload goes out most significant byte first
	task automatic send_frame(input logic [7:0] t, input logic [7:0] id, input int n,
		input logic [23:0] pay);
		logic [7:0] bytes [$];
		bytes = {t, id, 8'(n)};
		for (int k = 0; k < n; k++) begin
			bytes.push_back(pay[8*(n-1-k) +: 8]);
		end
		foreach (bytes[k]) begin
			@(negedge reset);
			rx_char = bytes[k];
			rx_char_valid = 1'b1;
		end
		@(negedge reset);
		rx_char_valid = 1'b0;
	endtask

	// Waits for a whole frame, the watchdog bounds the wait
	task automatic pull_frame();
		while (tx_q.size() < 3 || tx_q.size() < 3 + int'(tx_q[2])) begin
			@(negedge reset);
		end
		frm = {};
		repeat (3 + int'(tx_q[2])) begin
			frm.push_back(tx_q.pop_front());
		end
	endtask

	task automatic check_byte(input string what, input logic [7:0] exp,
		input logic [7:0] act);
		if (act !== exp) begin
			$display("ERROR %s, %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_tag(input string what, input evt_tag_t exp, input evt_tag_t act);
		if (act !== exp) begin
			$display("ERROR %s, %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string what, input logic [GPIO_WIDTH-1:0] exp,
		input logic [GPIO_WIDTH-1:0] act);
		if (act !== exp) begin
			$display("ERROR %s, %s: expected %h, actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	// Setting value out of the payload, MSB first
	function automatic logic [GPIO_WIDTH-1:0] frame_word();
		logic [GPIO_WIDTH-1:0] w;
		w = '0;
		for (int k = 0; k < NB; k++) begin
			w = {w[GPIO_WIDTH-9:0], frm[3+k]};
		end
		return w;
	endfunction

	task automatic check_header(input logic [7:0] t, input logic [7:0] id,
		input logic [7:0] len);
		check_byte("type", t, frm[0]);
		check_byte("event id", id, frm[1]);
		check_byte("length", len, frm[2]);
	endtask

	task automatic check_version(input logic [7:0] id);
		check_header(CMD_VERSION, id, 8'd2);
		check_byte("major", VERSION_MAJOR, frm[3]);
		check_byte("minor", VERSION_MINOR, frm[4]);
	endtask

	task automatic check_event(input evt_tag_t tag, input logic [GPIO_WIDTH-1:0] bits);
		check_byte("type", TYPE_GPIO_EVT, frm[0]);
		check_tag("tag", tag, evt_tag_t'(frm[1]));
		check_byte("length", 8'(NB), frm[2]);
		check_word("inputs", bits, frame_word());
	endtask

	task automatic write_setting(input logic [7:0] sid, input logic [GPIO_WIDTH-1:0] value,
		input logic [7:0] id);
		send_frame(CMD_SET, id, NB + 1, {sid, value});
		pull_frame();
		check_header(TYPE_ACK, id, 8'd0);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_at_start = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("%s: %s, %0d errors", test_name,
			(errors == err_at_start) ? "ok" : "FAIL", errors - err_at_start);
	endtask

	task automatic test_version();
		logic [7:0] id;
		begin_test("version query");
		id = 8'(xorshift());
		send_frame(CMD_VERSION, id, 0, '0);
		pull_frame();
		check_version(id);
		end_test();
	endtask

	task automatic test_settings();
		logic [7:0] id;
		logic [GPIO_WIDTH-1:0] dir;
		logic [GPIO_WIDTH-1:0] lvl;
		begin_test("settings");
		id = 8'(xorshift());
		dir = GPIO_WIDTH'(xorshift());
		lvl = GPIO_WIDTH'(xorshift());
		write_setting(SET_ID_DIRECTION, dir, id);
		write_setting(SET_ID_LEVEL, lvl, id + 8'd1);
		@(negedge reset);
		check_word("gpio_oe", dir, gpio_oe);
		// Input-direction pins never drive
		check_word("gpio_out", lvl & dir, gpio_out);
		send_frame(CMD_GET, id, 1, {16'h0, SET_ID_LEVEL});
		pull_frame();
		check_header(TYPE_ACK, id, 8'(NB));
		check_word("level read", lvl, frame_word());
		end_test();
	endtask

	task automatic test_nak();
		logic [7:0] id;
		begin_test("error replies");
		id = 8'(xorshift());
		// Type no peer answers
		send_frame(8'h5a, id, 0, '0);
		pull_frame();
		check_header(TYPE_NAK, id, 8'd0);
		id = 8'(xorshift());
		send_frame(CMD_SET, id, NB + 1, {8'h71, 16'(xorshift())});
		pull_frame();
		check_header(TYPE_NAK, id, 8'd0);
		end_test();
	endtask

	task automatic test_events();
		begin_test("gpio events");
		// Nibbles 0 and 2 drive, 1 and 3 are inputs
		dir_set = 16'h0f0f;
		write_setting(SET_ID_DIRECTION, dir_set, 8'h30);
		repeat (2) begin
			// Bit 4 always toggles, so an input bit changes
			gpio_in = gpio_in ^ (16'(xorshift()) | 16'h0010);
			pull_frame();
			check_event(evt_cnt, gpio_in & ~dir_set);
			evt_cnt++;
			repeat (20) @(negedge reset);
		end
		gpio_in = gpio_in ^ dir_set;
		repeat (40) @(negedge reset);
		if (tx_q.size() != 0 || tx_pos != 0) begin
			$display("%s: an output-direction pin change produced a frame", test_name);
			errors++;
		end
		end_test();
	endtask

	task automatic test_concurrent();
		logic [7:0] id;
		int seen_ver;
		int seen_evt;
		begin_test("concurrent responders");
		id = 8'(xorshift());
		seen_ver = 0;
		seen_evt = 0;
		gpio_in = gpio_in ^ 16'h0020;
		send_frame(CMD_VERSION, id, 0, '0);
		// Either peer may win the response bus first
		repeat (2) begin
			pull_frame();
			if (frm[0] == CMD_VERSION) begin
				check_version(id);
				seen_ver++;
			end else if (frm[0] == TYPE_GPIO_EVT) begin
				check_event(evt_cnt, gpio_in & ~dir_set);
				seen_evt++;
			end else begin
				$display("ERROR %s, frame type: expected 56 or 67, actual %h",
					test_name, frm[0]);
				errors++;
			end
		end
		evt_cnt++;
		if (seen_ver != 1 || seen_evt != 1) begin
			$display("%s: expected one version reply and one event frame", test_name);
			errors++;
		end
		end_test();
	endtask

	initial begin
		clk = 1'b1;
		rx_char = '0;
		rx_char_valid = 1'b0;
		gpio_in = '0;
		dir_set = '0;
		test_name = "reset";
		repeat (3) @(posedge reset);
		@(negedge reset);
		clk = 1'b0;
		test_version();
		test_settings();
		test_nak();
		test_events();
		test_concurrent();
		errors += u_ice_bus.u_props.fail_cnt;
		$display("%0d tests run, %0d errors, %0d assertion failures, %0d cycles",
			tests, errors, u_ice_bus.u_props.fail_cnt, cycles);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- compile.f
ice_bus_pkg.sv
ice_cfg_pkg.sv
ice_ma_if.sv
ice_frame_ctrl.sv
ice_resp_arbiter.sv
ice_basics.sv
ice_gpio.sv
ice_bus.sv
ice_bus_properties.sv
tb_ice_bus.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_ice_bus -f compile.f
out=$(./obj_dir/Vtb_ice_bus +verilator+error+limit+1000) || true
echo "$out"
if echo "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
